/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := executeStageTb
FILELIST  := executeStage.f
OBJDIR    := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# a $fatal in the testbench gives a nonzero exit status
run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* executeStage.f */
source/execPkg.sv
source/forwardPkg.sv
source/operandForward.sv
source/aluUnit.sv
source/branchTarget.sv
source/resultSelect.sv
source/executeStage.sv
sim/clockGen.sv
sim/executeStageTb.sv

/* sim/clockGen.sv */
`timescale 1ns/100ps
`default_nettype none
module clockGen (
   output logic clk,
   output logic rstN
);

   // 4 ns period, rising edges at 2, 6, 10 ...
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // low for three rising edges, released on the third
   initial begin
      rstN = 1'b0;
      repeat (3) @(posedge clk);
      rstN <= 1'b1;
   end

endmodule
`default_nettype wire

/* sim/executeCases.txt */
# name aluOp invA invB cin brchCond aluJmp jalSel setOpSel immSrc imm incPc inA inB fwdA fwdB
# stuSel ldFwFlag wrtDataIn, then expected aluFinal newPc addPc wrtDataOut, all hex
addBasic    0 0 0 0 0 0 0 0 0 000 0100 1234 0f0f 0 0 0 0 0000 2143 0100 0100 0f0f
subBasic    0 0 1 1 0 0 0 0 0 000 0100 1234 0f0f 0 0 0 0 0000 0325 0100 0100 0f0f
andBasic    1 0 0 0 0 0 0 0 0 000 0100 f0f0 3c3c 0 0 0 0 0000 3030 0100 0100 3c3c
orBasic     2 0 0 0 0 0 0 0 0 000 0100 f0f0 3c3c 0 0 0 0 0000 fcfc 0100 0100 3c3c
xorBasic    3 0 0 0 0 0 0 0 0 000 0100 f0f0 3c3c 0 0 0 0 0000 cccc 0100 0100 3c3c
rolBy4      4 0 0 0 0 0 0 0 0 000 0100 8001 0004 0 0 0 0 0000 0018 0100 0100 0004
sllBy4      5 0 0 0 0 0 0 0 0 000 0100 00f3 0004 0 0 0 0 0000 0f30 0100 0100 0004
rorBy4      6 0 0 0 0 0 0 0 0 000 0100 8001 0004 0 0 0 0 0000 1800 0100 0100 0004
srlBy8      7 0 0 0 0 0 0 0 0 000 0100 f000 0008 0 0 0 0 0000 00f0 0100 0100 0008
fwdXPcXAlu  0 0 0 0 0 0 0 0 0 000 0100 ffff ffff 8 a 0 0 0000 4444 0100 0100 1111
fwdXAluXImm 0 0 0 0 0 0 0 0 0 000 0100 ffff ffff a b 0 0 0000 3333 0100 0100 2222
fwdXImmMPc  0 0 0 0 0 0 0 0 0 000 0100 ffff ffff b c 0 0 0000 9999 0100 0100 7777
fwdMPcMMem  0 0 0 0 0 0 0 0 0 000 0100 ffff ffff c d 0 0 0000 dddd 0100 0100 6666
fwdMMemMAlu 0 0 0 0 0 0 0 0 0 000 0100 ffff ffff d e 0 0 0000 aaaa 0100 0100 4444
fwdMAluMImm 0 0 0 0 0 0 0 0 0 000 0100 ffff ffff e f 0 0 0000 9999 0100 0100 5555
fwdMImmXPc  0 0 0 0 0 0 0 0 0 000 0100 ffff ffff f 8 0 0 0000 8888 0100 0100 3333
beqzTaken   8 0 0 0 1 0 0 0 0 010 0100 0000 0000 0 0 0 0 0000 0000 0110 0110 0000
bnezNot     8 0 0 0 2 0 0 0 0 010 0100 0000 0000 0 0 0 0 0000 0000 0100 0100 0000
bltzBack    8 0 0 0 3 0 0 0 0 4f0 0100 0000 8000 0 0 0 0 0000 8000 00f0 00f0 8000
bgezFar     8 0 0 0 4 0 0 0 1 400 0800 0000 0001 0 0 0 0 0000 0001 0400 0400 0001
seqEqual    0 0 1 1 5 0 0 1 0 000 0100 0005 0005 0 0 0 0 0000 0001 0100 0100 0005
sltNeg      0 0 1 1 6 0 0 1 0 000 0100 fffe 0003 0 0 0 0 0000 0001 0100 0100 0003
sltOvfl     0 0 1 1 6 0 0 1 0 000 0100 8000 0001 0 0 0 0 0000 0001 0100 0100 0001
sleGreater  0 0 1 1 7 0 0 1 0 000 0100 0007 0003 0 0 0 0 0000 0000 0100 0100 0003
scoCarry    0 0 1 1 8 0 0 1 0 000 0100 0005 0003 0 0 0 0 0000 0001 0100 0100 0003
jalrReg     0 0 0 0 0 1 1 0 0 000 0100 2000 0040 0 0 0 0 0000 2040 2040 0100 0040
jalBack     8 0 0 0 1 0 1 0 1 7ff 0100 0000 0000 0 0 0 0 0000 0000 00ff 0100 0000
stBase      0 0 0 0 0 0 0 0 0 000 0100 1000 0004 0 a 1 0 beef 1004 0100 0100 beef
stLdFwd     0 0 0 0 0 0 0 0 0 000 0100 1000 0004 0 a 1 1 beef 1004 0100 0100 1111
ldFwdNoSt   0 0 0 0 0 0 0 0 0 000 0100 1000 0004 0 a 0 1 beef 2111 0100 0100 beef

/* sim/executeStageTb.sv */
`timescale 1ns/100ps
`default_nettype none
module executeStageTb import execPkg::*, forwardPkg::*; ();

   logic clk;
   logic rstN;
   dataT inA = '0, inB = '0, incPc = '0, wrtDataIn = '0;
   logic [imm11Width-1:0] imm = '0;
   logic immSrc = 1'b0, invA = 1'b0, invB = 1'b0, cin = 1'b0;
   logic aluJmp = 1'b0, jalSel = 1'b0, setOpSel = 1'b0;
   logic stuSel = 1'b0, ldFwFlag = 1'b0;
   aluOpT aluOp = opAdd;
   brchCondT brchCond = condNone;
   fwdCtrlU fwdA = '0, fwdB = '0;
   // each bypass lane carries its own marker word
   dataT x2xAddPc = 16'h3333, x2xAlu = 16'h1111, x2xImm8 = 16'h2222;
   dataT m2xAddPc = 16'h7777, m2xMem = 16'h6666, m2xAlu = 16'h4444, m2xImm8 = 16'h5555;
   logic inValid = 1'b0;
   logic outReady = 1'b1;
   logic inReady;
   logic outValid;
   dataT aluFinal, newPc, addPc, aluOut, wrtDataOut;

   // expected results in acceptance order
   string expName[$];
   dataT expFinal[$];
   dataT expNewPc[$];
   dataT expAddPc[$];
   dataT expAluOut[$];
   dataT expWrt[$];
   logic expSet[$];

   integer seed = 53;
   logic lastAccept = 1'b0;
   int received = 0;
   int numCases;
   int fd;
   int fields;
   int waitCount;
   string line;
   string caseName;
   dataT col [22];

   clockGen i_clockGen (.clk(clk), .rstN(rstN));

   executeStage i_executeStage (.*);

   task automatic failRun();
      $display("Simulation failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic abortRun(input string why);
      $display("Error: %s", why);
      failRun();
   endtask

   task automatic checkData(input string name, input dataT expected, input dataT actual);
      if (actual !== expected) begin
         $display("Mismatch %s: expected %h actual %h", name, expected, actual);
         failRun();
      end
   endtask

   task automatic checkFlag(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("Mismatch %s: expected %b actual %b", name, expected, actual);
         failRun();
      end
   endtask

   // oldest pending case against the word now leaving the stage
   task automatic compareResult();
      string nm;
      logic isSet;
      dataT eFin;
      nm = expName.pop_front();
      isSet = expSet.pop_front();
      eFin = expFinal.pop_front();
      received++;
      if (isSet)
         checkFlag({nm, ".take"}, eFin[0], aluFinal[0]);
      // upper bits of a set result must be zero
      checkData({nm, ".aluFinal"}, eFin, aluFinal);
      checkData({nm, ".newPc"}, expNewPc.pop_front(), newPc);
      checkData({nm, ".addPc"}, expAddPc.pop_front(), addPc);
      checkData({nm, ".aluOut"}, expAluOut.pop_front(), aluOut);
      checkData({nm, ".wrtDataOut"}, expWrt.pop_front(), wrtDataOut);
   endtask

   // consumer drops ready about one cycle in four
   always @(posedge clk) begin
      outReady <= ($random(seed) & 3) != 0;
   end

   // values here are the ones settled before the edge
   always @(posedge clk) begin
      if (lastAccept && !outValid)
         abortRun("result not valid one cycle after acceptance");
      if (outValid && outReady) begin
         if (expName.size() == 0)
            abortRun("output appeared with no accepted case pending");
         compareResult();
      end
      lastAccept = rstN && inValid && inReady;
   end

   initial begin
      fd = $fopen("sim/executeCases.txt", "r");
      if (fd == 0)
         abortRun("cannot open sim/executeCases.txt");
      waitCount = 0;
      while (rstN !== 1'b1) begin
         @(posedge clk);
         waitCount++;
         if (waitCount > 20)
            abortRun("reset was never released");
      end
      checkFlag("afterReset.outValid", 1'b0, outValid);
      checkFlag("afterReset.inReady", 1'b1, inReady);
      numCases = 0;
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         // skip blank and comment lines
         if (line.len() < 2 || line[0] == "#")
            continue;
         fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            caseName, col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
            col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15],
            col[16], col[17], col[18], col[19], col[20], col[21]);
         if (fields != 23)
            abortRun({"malformed line in case file: ", line});
         aluOp <= aluOpT'(col[0][3:0]);
         invA <= col[1][0];
         invB <= col[2][0];
         cin <= col[3][0];
         brchCond <= brchCondT'(col[4][3:0]);
         aluJmp <= col[5][0];
         jalSel <= col[6][0];
         setOpSel <= col[7][0];
         immSrc <= col[8][0];
         imm <= col[9][imm11Width-1:0];
         incPc <= col[10];
         inA <= col[11];
         inB <= col[12];
         fwdA <= fwdCtrlU'(col[13][3:0]);
         fwdB <= fwdCtrlU'(col[14][3:0]);
         stuSel <= col[15][0];
         ldFwFlag <= col[16][0];
         wrtDataIn <= col[17];
         inValid <= 1'b1;
         expName.push_back(caseName);
         expSet.push_back(col[7][0]);
         expFinal.push_back(col[18]);
         expNewPc.push_back(col[19]);
         expAddPc.push_back(col[20]);
         // set cases leave the difference A minus B on aluOut
         // other cases pass aluOut straight through as aluFinal
         expAluOut.push_back(col[7][0] ? dataT'(col[11] - col[12]) : col[18]);
         expWrt.push_back(col[21]);
         numCases++;
         // hold the case until the stage takes it
         waitCount = 0;
         do begin
            @(posedge clk);
            waitCount++;
            if (waitCount > 20)
               abortRun({"case not accepted in time: ", caseName});
         end while (!inReady);
      end
      $fclose(fd);
      inValid <= 1'b0;
      // drain whatever is still in the output register
      waitCount = 0;
      while (expName.size() != 0) begin
         @(posedge clk);
         waitCount++;
         if (waitCount > 20)
            abortRun("outValid did not come back for the remaining cases");
      end
      if (received == numCases && numCases > 0) begin
         $display("Simulation completed successfully");
         $finish;
      end else begin
         abortRun("number of results does not match the number of cases");
      end
   end

endmodule
`default_nettype wire

/* source/aluUnit.sv */
`timescale 1ns/100ps
`default_nettype none
module aluUnit import execPkg::*; (
   input  dataT  opA,
   input  dataT  opB,
   input  aluOpT aluOp,
   input  logic  invA,
   input  logic  invB,
   input  logic  cin,
   output dataT  aluOut,
   output logic  zeroF,
   output logic  signF,
   output logic  oflF,
   output logic  carryF
);

   dataT aIn;
   dataT bIn;
   logic [dataWidth:0] sumWide;
   logic [3:0] shAmt;
   logic [2*dataWidth-1:0] rolWide;
   logic [2*dataWidth-1:0] rorWide;

   // optional inversion ahead of every operation
   assign aIn = invA ? ~opA : opA;
   assign bIn = invB ? ~opB : opB;

   // subtract is add with invB and cin set
   assign sumWide = {1'b0, aIn} + {1'b0, bIn} + {{dataWidth{1'b0}}, cin};

   assign shAmt = bIn[3:0];
   // doubled word so the bits shifted out wrap back in
   assign rolWide = {aIn, aIn} << shAmt;
   assign rorWide = {aIn, aIn} >> shAmt;

   always_comb begin
      oflF = 1'b0;
      carryF = 1'b0;
      case (aluOp)
         opAdd: begin
            aluOut = sumWide[dataWidth-1:0];
            carryF = sumWide[dataWidth];
            // signed overflow when like signs give an unlike result
            oflF = (aIn[dataWidth-1] == bIn[dataWidth-1]) &&
                   (sumWide[dataWidth-1] != aIn[dataWidth-1]);
         end
         opAnd:   aluOut = aIn & bIn;
         opOr:    aluOut = aIn | bIn;
         opXor:   aluOut = aIn ^ bIn;
         opRol:   aluOut = rolWide[2*dataWidth-1:dataWidth];
         opSll:   aluOut = aIn << shAmt;
         opRor:   aluOut = rorWide[dataWidth-1:0];
         opSrl:   aluOut = aIn >> shAmt;
         opPassB: aluOut = bIn;
         default: aluOut = '0;
      endcase
   end

   assign zeroF = (aluOut == '0);
   assign signF = aluOut[dataWidth-1];

   // branch and set logic downstream trusts these only after an add
   always_comb begin
      assert final ((aluOp == opAdd) || (!oflF && !carryF))
         else $error("aluUnit: arithmetic flags set by a non-add operation");
   end

endmodule
`default_nettype wire

/* source/branchTarget.sv */
`timescale 1ns/100ps
`default_nettype none
module branchTarget import execPkg::*; (
   input  dataT                  incPc,
   input  logic [imm11Width-1:0] imm,
   input  logic                  immSrc,
   output dataT                  target
);

   dataT immExt;
   dataT immExt8;
   dataT immExt11;

   // branches carry 8 bits, jumps carry 11
   assign immExt8  = {{(dataWidth-imm8Width){imm[imm8Width-1]}}, imm[imm8Width-1:0]};
   assign immExt11 = {{(dataWidth-imm11Width){imm[imm11Width-1]}}, imm};

   assign immExt = immSrc ? immExt11 : immExt8;

   // relative to the already incremented pc
   assign target = incPc + immExt;

endmodule
`default_nettype wire

/* source/execPkg.sv */
package execPkg;

   // datapath word size
   localparam int dataWidth = 16;

   // immediate field widths in the instruction
   localparam int imm8Width = 8;
   localparam int imm11Width = 11;

   typedef logic [dataWidth-1:0] dataT;

   // shifts and rotates take their amount from the low 4 bits of B
   typedef enum logic [3:0] {
      opAdd   = 4'h0,
      opAnd   = 4'h1,
      opOr    = 4'h2,
      opXor   = 4'h3,
      opRol   = 4'h4,
      opSll   = 4'h5,
      opRor   = 4'h6,
      opSrl   = 4'h7,
      opPassB = 4'h8
   } aluOpT;

   // nine conditions need a fourth bit
   typedef enum logic [3:0] {
      condNone = 4'h0,
      condEqz  = 4'h1,
      condNez  = 4'h2,
      condLtz  = 4'h3,
      condGez  = 4'h4,
      condSeq  = 4'h5,
      condSlt  = 4'h6,
      condSle  = 4'h7,
      condSco  = 4'h8
   } brchCondT;

endpackage

/* source/executeStage.sv */
`timescale 1ns/100ps
`default_nettype none
module executeStage import execPkg::*, forwardPkg::*; (
   input  logic                  clk,
   input  logic                  rstN,
   input  dataT                  inA,
   input  dataT                  inB,
   input  dataT                  incPc,
   input  logic [imm11Width-1:0] imm,
   input  logic                  immSrc,
   input  aluOpT                 aluOp,
   input  logic                  invA,
   input  logic                  invB,
   input  logic                  cin,
   input  brchCondT              brchCond,
   input  logic                  aluJmp,
   input  logic                  jalSel,
   input  logic                  setOpSel,
   input  fwdCtrlU               fwdA,
   input  fwdCtrlU               fwdB,
   input  dataT                  x2xAlu,
   input  dataT                  x2xImm8,
   input  dataT                  x2xAddPc,
   input  dataT                  m2xAlu,
   input  dataT                  m2xImm8,
   input  dataT                  m2xMem,
   input  dataT                  m2xAddPc,
   input  logic                  stuSel,
   input  logic                  ldFwFlag,
   input  dataT                  wrtDataIn,
   input  logic                  inValid,
   output logic                  inReady,
   output logic                  outValid,
   input  logic                  outReady,
   output dataT                  aluFinal,
   output dataT                  newPc,
   output dataT                  addPc,
   output dataT                  aluOut,
   output dataT                  wrtDataOut
);

   dataT opA;
   dataT opB;
   dataT wrtDataComb;
   dataT aluOutComb;
   dataT target;
   dataT aluFinalComb;
   dataT newPcComb;
   dataT addPcComb;
   logic zeroF;
   logic signF;
   logic oflF;
   logic carryF;

   operandForward i_operandForward (
      .inA(inA), .inB(inB), .fwdA(fwdA), .fwdB(fwdB),
      .x2xAlu(x2xAlu), .x2xImm8(x2xImm8), .x2xAddPc(x2xAddPc),
      .m2xAlu(m2xAlu), .m2xImm8(m2xImm8), .m2xMem(m2xMem), .m2xAddPc(m2xAddPc),
      .stuSel(stuSel), .ldFwFlag(ldFwFlag), .wrtDataIn(wrtDataIn),
      .opA(opA), .opB(opB), .wrtDataOut(wrtDataComb)
   );

   // alu and target adder run side by side
   aluUnit i_aluUnit (
      .opA(opA), .opB(opB), .aluOp(aluOp), .invA(invA), .invB(invB), .cin(cin),
      .aluOut(aluOutComb), .zeroF(zeroF), .signF(signF), .oflF(oflF), .carryF(carryF)
   );

   branchTarget i_branchTarget (
      .incPc(incPc), .imm(imm), .immSrc(immSrc), .target(target)
   );

   resultSelect i_resultSelect (
      .brchCond(brchCond), .zeroF(zeroF), .signF(signF), .oflF(oflF), .carryF(carryF),
      .aluOut(aluOutComb), .target(target), .incPc(incPc),
      .aluJmp(aluJmp), .jalSel(jalSel), .setOpSel(setOpSel),
      .aluFinal(aluFinalComb), .newPc(newPcComb), .addPc(addPcComb)
   );

   // room when empty or the consumer drains this cycle
   assign inReady = !outValid || outReady;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         outValid <= 1'b0;
      end else if (inReady) begin
         outValid <= inValid;
      end
   end

   // payload loads only on an accepted case
   always_ff @(posedge clk) begin
      if (inValid && inReady) begin
         aluFinal <= aluFinalComb;
         newPc <= newPcComb;
         addPc <= addPcComb;
         aluOut <= aluOutComb;
         wrtDataOut <= wrtDataComb;
      end
   end

   // a stalled result stays put until taken
   assert property (@(posedge clk) disable iff (!rstN)
      outValid && !outReady |=> outValid && $stable(aluFinal) && $stable(newPc) &&
         $stable(addPc) && $stable(aluOut) && $stable(wrtDataOut))
      else $error("executeStage: output changed while stalled");

endmodule
`default_nettype wire

/* source/forwardPkg.sv */
package forwardPkg;

   // one bypass lane per flat index, lane 1 is never driven
   localparam int numLanes = 8;

   // flat index = {fromMem, src}
   localparam logic [2:0] srcXAddPc = 3'd0;
   localparam logic [2:0] srcXAlu   = 3'd2;
   localparam logic [2:0] srcXImm8  = 3'd3;
   localparam logic [2:0] srcMAddPc = 3'd4;
   localparam logic [2:0] srcMMem   = 3'd5;
   localparam logic [2:0] srcMAlu   = 3'd6;
   localparam logic [2:0] srcMImm8  = 3'd7;

   // 2-bit source code of the fields view
   localparam logic [1:0] fwdSrcMem = 2'b01;

   // same 4-bit control word seen as split fields or as a flat lane index
   typedef union packed {
      struct packed {
         logic       enable;
         logic       fromMem;
         logic [1:0] src;
      } fields;
      struct packed {
         logic       enable;
         logic [2:0] idx;
      } index;
   } fwdCtrlU;

endpackage

/* source/operandForward.sv */
`timescale 1ns/100ps
`default_nettype none
module operandForward import execPkg::*, forwardPkg::*; (
   input  dataT    inA,
   input  dataT    inB,
   input  fwdCtrlU fwdA,
   input  fwdCtrlU fwdB,
   input  dataT    x2xAlu,
   input  dataT    x2xImm8,
   input  dataT    x2xAddPc,
   input  dataT    m2xAlu,
   input  dataT    m2xImm8,
   input  dataT    m2xMem,
   input  dataT    m2xAddPc,
   input  logic    stuSel,
   input  logic    ldFwFlag,
   input  dataT    wrtDataIn,
   output dataT    opA,
   output dataT    opB,
   output dataT    wrtDataOut
);

   dataT lanes [numLanes];
   dataT fwdBVal;

   // bypass lanes laid out by flat index
   assign lanes[srcXAddPc] = x2xAddPc;
   assign lanes[1]         = '0;
   assign lanes[srcXAlu]   = x2xAlu;
   assign lanes[srcXImm8]  = x2xImm8;
   assign lanes[srcMAddPc] = m2xAddPc;
   assign lanes[srcMMem]   = m2xMem;
   assign lanes[srcMAlu]   = m2xAlu;
   assign lanes[srcMImm8]  = m2xImm8;

   assign opA     = fwdA.index.enable ? lanes[fwdA.index.idx] : inA;
   assign fwdBVal = fwdB.index.enable ? lanes[fwdB.index.idx] : inB;

   // stores keep the base register on B, the forwarded value becomes store data
   assign opB = stuSel ? inB : fwdBVal;
   // load forwarding flips which path carries the store data
   assign wrtDataOut = ldFwFlag ? (stuSel ? fwdBVal : wrtDataIn)
                                : (stuSel ? wrtDataIn : fwdBVal);

   // ex-to-ex has no memory data yet
   always_comb begin
      assert final (!(fwdA.fields.enable && !fwdA.fields.fromMem && fwdA.fields.src == fwdSrcMem))
         else $error("operandForward: illegal ex-to-ex memory forward on A");
      assert final (!(fwdB.fields.enable && !fwdB.fields.fromMem && fwdB.fields.src == fwdSrcMem))
         else $error("operandForward: illegal ex-to-ex memory forward on B");
   end

endmodule
`default_nettype wire

/* source/resultSelect.sv */
`timescale 1ns/100ps
`default_nettype none
module resultSelect import execPkg::*; (
   input  brchCondT brchCond,
   input  logic     zeroF,
   input  logic     signF,
   input  logic     oflF,
   input  logic     carryF,
   input  dataT     aluOut,
   input  dataT     target,
   input  dataT     incPc,
   input  logic     aluJmp,
   input  logic     jalSel,
   input  logic     setOpSel,
   output dataT     aluFinal,
   output dataT     newPc,
   output dataT     addPc
);

   logic take;
   logic lessThan;
   dataT jumpPc;

   // signed less-than from a subtraction
   assign lessThan = signF ^ oflF;

   always_comb begin
      case (brchCond)
         // zero tests look at the register passed through the alu
         condEqz: take = zeroF;
         condNez: take = !zeroF;
         condLtz: take = signF;
         condGez: take = !signF;
         // set conditions read the subtraction flags
         condSeq: take = zeroF;
         condSlt: take = lessThan;
         condSle: take = zeroF | lessThan;
         condSco: take = carryF;
         default: take = 1'b0;
      endcase
   end

   assign jumpPc = take ? target : incPc;

   // register jumps take the alu sum as the new pc
   assign newPc = aluJmp ? aluOut : jumpPc;
   // link register gets the return address
   assign addPc = jalSel ? incPc : jumpPc;
   assign aluFinal = setOpSel ? {{(dataWidth-1){1'b0}}, take} : aluOut;

endmodule
`default_nettype wire
